/* hdl/ddr2_wb_pkg.sv */
package ddr2_wb_pkg;

   // ***************************************************************************
   // bus widths shared by the wishbone side and the app side.
   // ***************************************************************************

   // word address, same on both sides.
   localparam int ADDR_WIDTH     = 31;
   // one app word is half of a burst of four on a 64-bit DDR2 bus.
   localparam int APP_DATA_WIDTH = 128;
   // one mask bit per data byte.
   localparam int APP_MASK_WIDTH = APP_DATA_WIDTH / 8;

   typedef logic [ADDR_WIDTH-1:0]     app_addr_t;
   typedef logic [APP_DATA_WIDTH-1:0] app_data_t;
   typedef logic [APP_MASK_WIDTH-1:0] app_mask_t;

   // ***************************************************************************
   // app interface command codes and sequencer states.
   // ***************************************************************************

   // MIG address FIFO command field.
   typedef enum logic [2:0]
   {
      app_cmd_write = 3'd0,
      app_cmd_read  = 3'd1
   } app_cmd_t;

   // command sequencer states.
   typedef enum logic [2:0]
   {
      seq_idle     = 3'd0,
      seq_wr_d0    = 3'd1,
      seq_wr_d1    = 3'd2,
      seq_rd_cmd   = 3'd3,
      seq_wait_rsp = 3'd4,
      seq_rsp_end  = 3'd5,
      seq_timeout  = 3'd6
   } seq_state_t;

endpackage

/* hdl/bridge_cmd_if.sv */
`timescale 1ns/1ps

// one transaction from the wishbone port to the command sequencer.
// four-phase req/ack, all fields stable while req is high.
interface bridge_cmd_if
   import ddr2_wb_pkg::*;
   ();

   // handshake.
   logic      req;
   logic      ack;
   // transaction kind, high for a write.
   logic      we;
   // word address of the burst.
   app_addr_t addr;
   // write words and their app masks (1 = byte kept).
   app_data_t wdata0;
   app_data_t wdata1;
   app_mask_t wmask0;
   app_mask_t wmask1;
   // read timed out, valid while ack is high.
   logic      fail;

   // wishbone side.
   modport port
   (
      output req, we, addr, wdata0, wdata1, wmask0, wmask1,
      input  ack, fail
   );

   // sequencer side.
   modport seq
   (
      input  req, we, addr, wdata0, wdata1, wmask0, wmask1,
      output ack, fail
   );

endinterface

/* hdl/wb_slave_port.sv */
`timescale 1ns/1ps

module wb_slave_port
   import ddr2_wb_pkg::*;
(
   input  logic         clk0_tb,
   input  logic         rst0_tb,
   input  logic         cyc,
   input  logic         stb,
   input  logic         we,
   input  app_addr_t    address,
   input  app_mask_t    sel,
   input  app_data_t    wr_data,
   output app_data_t    rd_data,
   output logic         ack,
   output logic         err,
   output logic         rty,
   input  logic         phy_init_done,
   bridge_cmd_if.port   cmd,
   input  logic         beat_valid,
   input  app_data_t    beat_data,
   output logic         pop
);

   // beat phases of one two-beat transaction.
   localparam logic [2:0] PH_IDLE    = 3'd0;
   localparam logic [2:0] PH_WR1     = 3'd1;
   localparam logic [2:0] PH_WR_WAIT = 3'd2;
   localparam logic [2:0] PH_RD0     = 3'd3;
   localparam logic [2:0] PH_RD1     = 3'd4;

   logic [2:0] phase;
   logic       resp;
   logic       beat_in;
   logic       take0;

   // a beat is answered in the cycle after it is seen.
   // stb is still high in the answer cycle, so skip it there.
   assign resp    = ack | err | rty;
   assign beat_in = cyc & stb & ~resp;
   // no new transaction while the last handshake is still closing.
   assign take0   = beat_in & ~cmd.ack & (phase == PH_IDLE);

   // ***************************************************************************
   // beat sequencing and answers.
   // ***************************************************************************
   always_ff @(posedge clk0_tb)
   begin
      if (rst0_tb)
      begin
         phase   <= PH_IDLE;
         ack     <= 1'b0;
         err     <= 1'b0;
         rty     <= 1'b0;
         pop     <= 1'b0;
         cmd.req <= 1'b0;
      end
      else
      begin
         // answers are single-cycle pulses.
         ack <= 1'b0;
         err <= 1'b0;
         rty <= 1'b0;
         pop <= 1'b0;
         // phase 3 of the handshake.
         if (cmd.ack)
            cmd.req <= 1'b0;
         case (phase)
            PH_IDLE:
               if (take0)
               begin
                  // memory still calibrating, master must retry.
                  if (!phy_init_done)
                     rty <= 1'b1;
                  else if (we)
                  begin
                     ack   <= 1'b1;
                     phase <= PH_WR1;
                  end
                  else
                  begin
                     cmd.req <= 1'b1;
                     phase   <= PH_RD0;
                  end
               end
            PH_WR1:
               // both words held, hand the write over.
               if (beat_in)
               begin
                  cmd.req <= 1'b1;
                  phase   <= PH_WR_WAIT;
               end
            PH_WR_WAIT:
               // last write beat waits for the command ack.
               if (cmd.ack)
               begin
                  ack   <= 1'b1;
                  phase <= PH_IDLE;
               end
            PH_RD0, PH_RD1:
               if (cmd.ack && cmd.fail)
               begin
                  err   <= 1'b1;
                  phase <= PH_IDLE;
               end
               else if (beat_in && beat_valid)
               begin
                  ack   <= 1'b1;
                  pop   <= 1'b1;
                  phase <= (phase == PH_RD0) ? PH_RD1 : PH_IDLE;
               end
            default:
               phase <= PH_IDLE;
         endcase
      end
   end

   // beat payload.
   always_ff @(posedge clk0_tb)
   begin
      if (take0)
      begin
         cmd.addr   <= address;
         cmd.we     <= we;
         cmd.wdata0 <= wr_data;
         // app mask bit set means byte not written.
         cmd.wmask0 <= ~sel;
      end
      if ((phase == PH_WR1) && beat_in)
      begin
         cmd.wdata1 <= wr_data;
         cmd.wmask1 <= ~sel;
      end
      if (((phase == PH_RD0) || (phase == PH_RD1)) && beat_in && beat_valid)
         rd_data <= beat_data;
   end

   // a new request only once the last ack has dropped.
   a_req_after_ack: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
      $rose(cmd.req) |-> !$past(cmd.ack))
      else $error("req raised while ack still high");

endmodule

/* hdl/app_cmd_sequencer.sv */
`timescale 1ns/1ps

module app_cmd_sequencer
   import ddr2_wb_pkg::*;
#(
   parameter int RD_TIMEOUT_CYCLES = 24
)
(
   input  logic         clk0_tb,
   input  logic         rst0_tb,
   bridge_cmd_if.seq    cmd,
   output logic         af_wren,
   output app_cmd_t     af_cmd,
   output app_addr_t    af_addr,
   input  logic         af_afull,
   output logic         wdf_wren,
   output app_data_t    wdf_data,
   output app_mask_t    wdf_mask,
   input  logic         wdf_afull,
   input  logic         rsp_done,
   output logic         flush
);

   localparam int CNT_W = $clog2(RD_TIMEOUT_CYCLES + 1);

   seq_state_t       state;
   logic [CNT_W-1:0] tmo_cnt;
   logic             wr_ok;

   // command and first word go out together, so both FIFOs need room.
   assign wr_ok = ~af_afull & ~wdf_afull;

   // ***************************************************************************
   // command state machine.
   // ***************************************************************************
   always_ff @(posedge clk0_tb)
   begin
      if (rst0_tb)
      begin
         state    <= seq_idle;
         tmo_cnt  <= '0;
         cmd.ack  <= 1'b0;
         cmd.fail <= 1'b0;
      end
      else
      begin
         case (state)
            seq_idle:
               // close the handshake first, then take the next request.
               if (cmd.ack)
               begin
                  if (!cmd.req)
                     cmd.ack <= 1'b0;
               end
               else if (cmd.req)
                  state <= cmd.we ? seq_wr_d0 : seq_rd_cmd;
            seq_wr_d0:
               if (wr_ok)
                  state <= seq_wr_d1;
            seq_wr_d1:
               if (!wdf_afull)
               begin
                  cmd.ack  <= 1'b1;
                  cmd.fail <= 1'b0;
                  state    <= seq_idle;
               end
            seq_rd_cmd:
               if (!af_afull)
               begin
                  tmo_cnt <= CNT_W'(RD_TIMEOUT_CYCLES);
                  state   <= seq_wait_rsp;
               end
            seq_wait_rsp:
               // both words in the buffer ends the wait.
               if (rsp_done)
                  state <= seq_rsp_end;
               else if (tmo_cnt == '0)
                  state <= seq_timeout;
               else
                  tmo_cnt <= tmo_cnt - 1'b1;
            seq_rsp_end:
            begin
               cmd.ack  <= 1'b1;
               cmd.fail <= 1'b0;
               state    <= seq_idle;
            end
            seq_timeout:
            begin
               // no answer from memory.
               cmd.ack  <= 1'b1;
               cmd.fail <= 1'b1;
               state    <= seq_idle;
            end
            default:
               state <= seq_idle;
         endcase
      end
   end

   // ***************************************************************************
   // app interface strobes and payload.
   // ***************************************************************************
   assign af_wren  = ((state == seq_wr_d0) && wr_ok) ||
                     ((state == seq_rd_cmd) && !af_afull);
   assign af_cmd   = (state == seq_rd_cmd) ? app_cmd_read : app_cmd_write;
   assign af_addr  = cmd.addr;
   assign wdf_wren = ((state == seq_wr_d0) && wr_ok) ||
                     ((state == seq_wr_d1) && !wdf_afull);
   // word 1 only in its own state.
   assign wdf_data = (state == seq_wr_d1) ? cmd.wdata1 : cmd.wdata0;
   assign wdf_mask = (state == seq_wr_d1) ? cmd.wmask1 : cmd.wmask0;
   // stale words from a late answer must not reach the next read.
   assign flush    = (state == seq_timeout);

   // ack only answers a live request.
   a_ack_req: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
      $rose(cmd.ack) |-> cmd.req)
      else $error("ack raised without req");

endmodule

/* hdl/rd_response_buffer.sv */
`timescale 1ns/1ps

module rd_response_buffer
   import ddr2_wb_pkg::*;
(
   input  logic      clk0_tb,
   input  logic      rst0_tb,
   input  logic      rd_data_valid,
   input  app_data_t rd_data_fifo_out,
   input  logic      flush,
   output logic      rsp_done,
   output logic      beat_valid,
   output app_data_t beat_data,
   input  logic      pop
);

   // two words per burst of four.
   app_data_t  mem [2];
   // bit 1 counts the second word, bit 0 selects the entry.
   logic [1:0] wr_ptr;
   logic [1:0] rd_ptr;

   always_ff @(posedge clk0_tb)
   begin
      if (rst0_tb || flush)
      begin
         wr_ptr <= 2'd0;
         rd_ptr <= 2'd0;
      end
      else
      begin
         if (rd_data_valid && !wr_ptr[1])
            wr_ptr <= wr_ptr + 2'd1;
         // last word out, ready for the next burst.
         if (pop && beat_valid)
         begin
            if ((rd_ptr == 2'd1) && (wr_ptr == 2'd2))
            begin
               wr_ptr <= 2'd0;
               rd_ptr <= 2'd0;
            end
            else
               rd_ptr <= rd_ptr + 2'd1;
         end
      end
   end

   always_ff @(posedge clk0_tb)
   begin
      if (rd_data_valid && !wr_ptr[1])
         mem[wr_ptr[0]] <= rd_data_fifo_out;
   end

   assign rsp_done   = wr_ptr[1];
   assign beat_valid = (wr_ptr != rd_ptr);
   assign beat_data  = mem[rd_ptr[0]];

   // memory must not answer more than one burst per command.
   a_no_overrun: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
      rd_data_valid |-> (wr_ptr != 2'd2))
      else $error("read word arrived with buffer full");

endmodule

/* hdl/ddr2_wb_bridge.sv */
`timescale 1ns/1ps

module ddr2_wb_bridge
   import ddr2_wb_pkg::*;
#(
   parameter int RD_TIMEOUT_CYCLES = 24
)
(
   input  logic      clk0_tb,
   input  logic      rst0_tb,
   // wishbone slave.
   input  logic      cyc,
   input  logic      stb,
   input  logic      we,
   input  app_addr_t address,
   input  app_mask_t sel,
   input  app_data_t wr_data,
   output app_data_t rd_data,
   output logic      ack,
   output logic      err,
   output logic      rty,
   // MIG user interface.
   output logic      af_wren,
   output app_cmd_t  af_cmd,
   output app_addr_t af_addr,
   input  logic      af_afull,
   output logic      wdf_wren,
   output app_data_t wdf_data,
   output app_mask_t wdf_mask,
   input  logic      wdf_afull,
   input  logic      rd_data_valid,
   input  app_data_t rd_data_fifo_out,
   input  logic      phy_init_done
);

   bridge_cmd_if cmd_if ();

   logic      rsp_done;
   logic      flush;
   logic      beat_valid;
   app_data_t beat_data;
   logic      pop;

   // wishbone beats in, one transaction out.
   wb_slave_port u_port
   (
      .clk0_tb       (clk0_tb),
      .rst0_tb       (rst0_tb),
      .cyc           (cyc),
      .stb           (stb),
      .we            (we),
      .address       (address),
      .sel           (sel),
      .wr_data       (wr_data),
      .rd_data       (rd_data),
      .ack           (ack),
      .err           (err),
      .rty           (rty),
      .phy_init_done (phy_init_done),
      .cmd           (cmd_if.port),
      .beat_valid    (beat_valid),
      .beat_data     (beat_data),
      .pop           (pop)
   );

   // app commands and write words.
   app_cmd_sequencer #(
      .RD_TIMEOUT_CYCLES (RD_TIMEOUT_CYCLES)
   ) u_seq
   (
      .clk0_tb   (clk0_tb),
      .rst0_tb   (rst0_tb),
      .cmd       (cmd_if.seq),
      .af_wren   (af_wren),
      .af_cmd    (af_cmd),
      .af_addr   (af_addr),
      .af_afull  (af_afull),
      .wdf_wren  (wdf_wren),
      .wdf_data  (wdf_data),
      .wdf_mask  (wdf_mask),
      .wdf_afull (wdf_afull),
      .rsp_done  (rsp_done),
      .flush     (flush)
   );

   // read words back to the port.
   rd_response_buffer u_rdbuf
   (
      .clk0_tb          (clk0_tb),
      .rst0_tb          (rst0_tb),
      .rd_data_valid    (rd_data_valid),
      .rd_data_fifo_out (rd_data_fifo_out),
      .flush            (flush),
      .rsp_done         (rsp_done),
      .beat_valid       (beat_valid),
      .beat_data        (beat_data),
      .pop              (pop)
   );

endmodule

/* testbench/ddr2_app_model.sv */
`timescale 1ns/1ps

// behavioural MIG user interface with a flat word store.
module ddr2_app_model
   import ddr2_wb_pkg::*;
(
   input  logic      clk0_tb,
   input  logic      rst0_tb,
   input  logic      af_wren,
   input  app_cmd_t  af_cmd,
   input  app_addr_t af_addr,
   output logic      af_afull,
   input  logic      wdf_wren,
   input  app_data_t wdf_data,
   input  app_mask_t wdf_mask,
   output logic      wdf_afull,
   output logic      rd_data_valid,
   output app_data_t rd_data_fifo_out,
   output logic      phy_init_done
);

   // calibration time and read latency in cycles.
   localparam int INIT_CYCLES = 40;
   localparam int RD_LATENCY  = 6;

   // words keyed by {address, word index}.
   app_data_t store [logic [ADDR_WIDTH:0]];

   // DUT outputs as seen on the rising edge.
   logic      s_rst;
   logic      s_af_wren;
   app_cmd_t  s_af_cmd;
   app_addr_t s_af_addr;
   logic      s_wdf_wren;
   app_data_t s_wdf_data;
   app_mask_t s_wdf_mask;

   always @(posedge clk0_tb)
   begin
      s_rst      <= rst0_tb;
      s_af_wren  <= af_wren;
      s_af_cmd   <= af_cmd;
      s_af_addr  <= af_addr;
      s_wdf_wren <= wdf_wren;
      s_wdf_data <= wdf_data;
      s_wdf_mask <= wdf_mask;
   end

   // unwritten memory reads as zero.
   function automatic app_data_t fetch(input app_addr_t a, input logic idx);
      if (store.exists({a, idx}))
         return store[{a, idx}];
      return '0;
   endfunction

   // ***************************************************************************
   // status and read data, driven on the falling edge.
   // ***************************************************************************
   initial
   begin : drive
      int        init_cnt;
      int        cmd_cnt;
      int        word_cnt;
      int        af_hold;
      int        wdf_hold;
      int        rd_wait;
      int        rd_beats;
      int        b;
      app_addr_t wr_addr;
      app_addr_t rd_addr;
      logic      wr_idx;
      app_data_t word;
      af_afull         = 1'b0;
      wdf_afull        = 1'b0;
      rd_data_valid    = 1'b0;
      rd_data_fifo_out = '0;
      phy_init_done    = 1'b0;
      forever
      begin
         @(negedge clk0_tb);
         if (s_rst)
         begin
            init_cnt      = 0;
            cmd_cnt       = 0;
            word_cnt      = 0;
            af_hold       = 0;
            wdf_hold      = 0;
            rd_wait       = 0;
            rd_beats      = 0;
            wr_idx        = 1'b0;
            phy_init_done = 1'b0;
            rd_data_valid = 1'b0;
         end
         else
         begin
            // calibration delay.
            if (init_cnt < INIT_CYCLES)
               init_cnt++;
            phy_init_done = (init_cnt >= INIT_CYCLES);
            if (af_hold > 0)
               af_hold--;
            if (wdf_hold > 0)
               wdf_hold--;
            // two back-to-back words per read.
            rd_data_valid = 1'b0;
            if (rd_beats > 0)
            begin
               rd_data_valid    = 1'b1;
               rd_data_fifo_out = fetch(rd_addr, rd_beats == 1);
               rd_beats--;
            end
            else if (rd_wait > 0)
            begin
               rd_wait--;
               if (rd_wait == 0)
               begin
                  rd_data_valid    = 1'b1;
                  rd_data_fifo_out = fetch(rd_addr, 1'b0);
                  rd_beats         = 1;
               end
            end
            // new command, stall after every third.
            if (s_af_wren)
            begin
               cmd_cnt++;
               if (cmd_cnt % 3 == 0)
                  af_hold = 3;
               if (s_af_cmd == app_cmd_write)
               begin
                  wr_addr = s_af_addr;
                  wr_idx  = 1'b0;
               end
               // bit 30 region never answers.
               else if (!s_af_addr[ADDR_WIDTH-1])
               begin
                  rd_addr = s_af_addr;
                  rd_wait = RD_LATENCY - 1;
               end
            end
            // masked word write, mask bit set keeps the byte.
            if (s_wdf_wren)
            begin
               word = fetch(wr_addr, wr_idx);
               for (b = 0; b < APP_MASK_WIDTH; b++)
                  if (!s_wdf_mask[b])
                     word[8*b +: 8] = s_wdf_data[8*b +: 8];
               store[{wr_addr, wr_idx}] = word;
               wr_idx = 1'b1;
               word_cnt++;
               if (word_cnt % 5 == 0)
                  wdf_hold = 2;
            end
            af_afull  = (af_hold > 0);
            wdf_afull = (wdf_hold > 0);
         end
      end
   end

endmodule

/* testbench/tb_ddr2_wb_bridge.sv */
`timescale 1ns/1ps

module tb_ddr2_wb_bridge
   import ddr2_wb_pkg::*;
();

   // one stimulus line is six words.
   localparam int N_TRANS         = 16;
   localparam int N_FIELDS        = 6;
   localparam int WATCHDOG_CYCLES = N_TRANS * 200 + 100;

   // answer codes, as in the stimulus file.
   localparam logic [1:0] ANS_ACK = 2'd0;
   localparam logic [1:0] ANS_ERR = 2'd1;
   localparam logic [1:0] ANS_RTY = 2'd2;
   // kind 0 is a write, anything else a read.
   localparam logic [1:0] KIND_WRITE = 2'd0;

   logic      clk0_tb;
   logic      rst0_tb;
   logic      cyc;
   logic      stb;
   logic      we;
   app_addr_t address;
   app_mask_t sel;
   app_data_t wr_data;
   app_data_t rd_data;
   logic      ack;
   logic      err;
   logic      rty;
   logic      af_wren;
   app_cmd_t  af_cmd;
   app_addr_t af_addr;
   logic      af_afull;
   logic      wdf_wren;
   app_data_t wdf_data;
   app_mask_t wdf_mask;
   logic      wdf_afull;
   logic      rd_data_valid;
   app_data_t rd_data_fifo_out;
   logic      phy_init_done;

   logic [127:0] stim [N_TRANS*N_FIELDS];
   // expected memory contents, keyed by {address, word index}.
   app_data_t    shadow [logic [ADDR_WIDTH:0]];
   int           errors;

   ddr2_wb_bridge dut0 (.*);

   ddr2_app_model model0 (.*);

   initial
   begin
      clk0_tb = 1'b0;
      forever #4 clk0_tb = ~clk0_tb;
   end

   // ends a hung run.
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk0_tb);
      $display("timeout: stimulus not finished after %0d cycles", WATCHDOG_CYCLES);
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

   // ***************************************************************************
   // checks and expected data.
   // ***************************************************************************
   task automatic check_value(input app_data_t got, input app_data_t exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                  $time, what, got, exp);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic app_data_t expected_word(input app_addr_t a, input logic idx);
      if (shadow.exists({a, idx}))
         return shadow[{a, idx}];
      return '0;
   endfunction

   // sel bit set takes the new byte.
   function automatic app_data_t merge_sel(input app_data_t old_word,
                                           input app_data_t new_word,
                                           input app_mask_t s);
      app_data_t res;
      res = old_word;
      for (int b = 0; b < APP_MASK_WIDTH; b++)
         if (s[b])
            res[8*b +: 8] = new_word[8*b +: 8];
      return res;
   endfunction

   // app FIFOs take no write while almost full.
   always @(posedge clk0_tb)
   begin
      if (!rst0_tb)
      begin
         check_value(app_data_t'(af_wren & af_afull), '0,
                     "address FIFO written while almost full");
         check_value(app_data_t'(wdf_wren & wdf_afull), '0,
                     "write data FIFO written while almost full");
      end
   end

   // ***************************************************************************
   // wishbone master.
   // ***************************************************************************
   // starts and ends on a falling edge.
   task automatic bus_beat(input logic wr, input app_addr_t a, input app_mask_t s,
                           input app_data_t d, output logic [1:0] ans,
                           output app_data_t rword);
      cyc     = 1'b1;
      stb     = 1'b1;
      we      = wr;
      address = a;
      sel     = s;
      wr_data = d;
      do
         @(negedge clk0_tb);
      while (!(ack || err || rty));
      ans   = ack ? ANS_ACK : (err ? ANS_ERR : ANS_RTY);
      rword = rd_data;
   endtask

   task automatic bus_idle();
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      @(negedge clk0_tb);
   endtask

   // calibration flag changes on the falling edge.
   task automatic wait_for_init();
      do
         @(posedge clk0_tb);
      while (!phy_init_done);
      @(negedge clk0_tb);
   endtask

   task automatic run_line(input int t);
      logic [1:0] kind;
      logic [1:0] exp_ans;
      logic [1:0] ans;
      app_addr_t  a;
      app_data_t  d0;
      app_data_t  d1;
      app_mask_t  s;
      app_data_t  rword;
      kind    = stim[t*N_FIELDS][1:0];
      a       = stim[t*N_FIELDS+1][ADDR_WIDTH-1:0];
      d0      = stim[t*N_FIELDS+2];
      d1      = stim[t*N_FIELDS+3];
      s       = stim[t*N_FIELDS+4][APP_MASK_WIDTH-1:0];
      exp_ans = stim[t*N_FIELDS+5][1:0];
      // only the retry lines run before calibration ends.
      if (exp_ans != ANS_RTY)
         wait_for_init();
      bus_beat(kind == KIND_WRITE, a, s, d0, ans, rword);
      check_value(app_data_t'(ans), app_data_t'(exp_ans),
                  $sformatf("line %0d beat 0 answer", t));
      if (exp_ans == ANS_ACK)
      begin
         if (kind == KIND_WRITE)
         begin
            bus_beat(1'b1, a, s, d1, ans, rword);
            check_value(app_data_t'(ans), app_data_t'(ANS_ACK),
                        $sformatf("line %0d beat 1 answer", t));
            shadow[{a, 1'b0}] = merge_sel(expected_word(a, 1'b0), d0, s);
            shadow[{a, 1'b1}] = merge_sel(expected_word(a, 1'b1), d1, s);
         end
         else
         begin
            check_value(rword, expected_word(a, 1'b0), $sformatf("line %0d read word 0", t));
            bus_beat(1'b0, a, s, '0, ans, rword);
            check_value(app_data_t'(ans), app_data_t'(ANS_ACK),
                        $sformatf("line %0d beat 1 answer", t));
            check_value(rword, expected_word(a, 1'b1), $sformatf("line %0d read word 1", t));
         end
      end
      bus_idle();
   endtask

   // ***************************************************************************
   // main sequence.
   // ***************************************************************************
   initial
   begin
      rst0_tb = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      address = '0;
      sel     = '0;
      wr_data = '0;
      errors  = 0;
      $readmemh("testbench/bridge_stim.txt", stim);
      // reset over two rising edges.
      repeat (2) @(negedge clk0_tb);
      rst0_tb = 1'b0;
      for (int t = 0; t < N_TRANS; t++)
         run_line(t);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* testbench/bridge_stim.txt */
// kind address data0 data1 sel expect, one transaction per line
// kind 0 write, 1 read, 2 read that must fail; expect 0 ack, 1 err, 2 rty
0 00000100 11111111222222223333333344444444 55555555666666667777777788888888 ffff 2
0 00000100 0123456789abcdef0fedcba987654321 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c ffff 0
1 00000100 0 0 0 0
0 00000100 deadbeefcafef00d1122334455667788 99aabbccddeeff000102030405060708 00ff 0
1 00000100 0 0 0 0
0 00000200 f0e1d2c3b4a5968778695a4b3c2d1e0f 0f1e2d3c4b5a69788796a5b4c3d2e1f0 f0f0 0
1 00000200 0 0 0 0
2 40000100 0 0 0 1
1 00000100 0 0 0 0
0 00000300 00000000000000000000000000000001 80000000000000000000000000000000 ffff 0
0 00000304 13579bdf02468ace13579bdf02468ace fedcba9876543210fedcba9876543210 ffff 0
1 00000300 0 0 0 0
1 00000304 0 0 0 0
1 00000500 0 0 0 0
0 00000300 ffffffffffffffffffffffffffffffff eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee 0f0f 0
1 00000300 0 0 0 0

/* project.f */
hdl/ddr2_wb_pkg.sv
hdl/bridge_cmd_if.sv
hdl/wb_slave_port.sv
hdl/app_cmd_sequencer.sv
hdl/rd_response_buffer.sv
hdl/ddr2_wb_bridge.sv
testbench/ddr2_app_model.sv
testbench/tb_ddr2_wb_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_ddr2_wb_bridge -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF 'All tests passed!' <<< "$output"; then
   exit 0
fi
exit 1
